// ==== verilog/cnn_cfg.svh ====
`ifndef CNN_CFG_SVH
`define CNN_CFG_SVH

// image side in pixels, must be even
`define CNN_IMG_DIM     8

`define CNN_PIX_W       8   // signed int8 pixels
`define CNN_WGT_W       4   // weights and bias
`define CNN_ACC_W       16

// one bank per row parity and column parity
`define CNN_BANKS       4
`define CNN_BANK_AW     4   // a quarter of the image per bank

// nine pooled bytes packed four per word
`define CNN_RES_AW      2

`define CNN_BIAS_ALIGN  2   // bias scaled up before the add

// register map, weights at 0..8 in row-major order
`define CNN_REG_BIAS    4'd9
`define CNN_REG_SHIFT   4'd10

`endif

// ==== verilog/cnn_pkg.sv ====
`include "cnn_cfg.svh"

package cnn_pkg;

	typedef logic signed [`CNN_PIX_W-1:0] pixel_t;
	typedef logic signed [`CNN_WGT_W-1:0] weight_t;
	typedef logic signed [`CNN_ACC_W-1:0] acc_t;

	typedef logic [`CNN_BANK_AW-1:0] bank_addr_t;

	// kernel register file contents
	typedef struct packed {
		weight_t [8:0] w;      // w[0] is the top-left tap
		weight_t       bias;
		logic    [2:0] shift;  // arithmetic right shift before saturation
	} kernel_t;

	typedef struct packed {
		bank_addr_t [`CNN_BANKS-1:0] addr;
		logic                        stb;
	} bank_rd_t;

	// bank index is {row parity, col parity}
	typedef pixel_t [`CNN_BANKS-1:0] bank_data_t;

	typedef pixel_t [15:0] window_t;   // 4x4, element 0 top-left
	typedef acc_t [3:0] conv_quad_t;   // tl, tr, bl, br

	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		logic [3:0] adr;
		logic [7:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic       ack;
		logic [7:0] dat;
	} wb_rsp_t;

	// result memory write port
	typedef struct packed {
		logic                   wen;       // active low
		logic [`CNN_RES_AW-1:0] addr;
		logic [31:0]            data;
		logic [3:0]             bytemask;  // active low
	} res_wr_t;

endpackage

// ==== verilog/kernel_regs.sv ====
`include "cnn_cfg.svh"

module kernel_regs (
	input  logic             clk,
	input  logic             rst_n,
	input  cnn_pkg::wb_req_t wb_req,
	output cnn_pkg::wb_rsp_t wb_rsp,
	output cnn_pkg::kernel_t kernel
);
	import cnn_pkg::*;

	logic       ack_q;
	logic [7:0] rdat_q;
	logic [7:0] rdat;
	logic       access;   // first cycle of a strobe

	assign access = wb_req.cyc && wb_req.stb && !ack_q;

	// read mux, raw field bits zero-extended
	always_comb begin
		rdat = '0;
		if (wb_req.adr < `CNN_REG_BIAS) begin   // weights sit below the bias
			rdat[`CNN_WGT_W-1:0] = kernel.w[wb_req.adr];
		end else if (wb_req.adr == `CNN_REG_BIAS) begin
			rdat[`CNN_WGT_W-1:0] = kernel.bias;
		end else if (wb_req.adr == `CNN_REG_SHIFT) begin
			rdat[2:0] = kernel.shift;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			kernel <= '0;
			ack_q  <= 1'b0;
		end else begin
			ack_q <= access;   // single-cycle ack
			if (access && wb_req.we) begin
				if (wb_req.adr < `CNN_REG_BIAS) begin
					kernel.w[wb_req.adr] <= wb_req.dat[`CNN_WGT_W-1:0];
				end else if (wb_req.adr == `CNN_REG_BIAS) begin
					kernel.bias <= wb_req.dat[`CNN_WGT_W-1:0];
				end else if (wb_req.adr == `CNN_REG_SHIFT) begin
					kernel.shift <= wb_req.dat[2:0];
				end
				// anything above the shift register is dropped
			end
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			rdat_q <= rdat;
		end
	end

	assign wb_rsp = '{ack: ack_q, dat: rdat_q};

endmodule

// ==== verilog/image_bank_buffer.sv ====
`include "cnn_cfg.svh"

module image_bank_buffer (
	input  logic                clk,
	input  logic                wr_en,
	input  logic [1:0]          wr_bank,
	input  cnn_pkg::bank_addr_t wr_addr,
	input  cnn_pkg::pixel_t     wr_pixel,
	input  cnn_pkg::bank_rd_t   rd,
	output cnn_pkg::bank_data_t rd_data
);
	import cnn_pkg::*;

	// each bank holds one parity class, a quarter of the image
	localparam int DEPTH = (`CNN_IMG_DIM / 2) * (`CNN_IMG_DIM / 2);

	pixel_t mem [`CNN_BANKS][DEPTH];

	////////////////////////////////////////////////////////////////////////////
	// streaming write side, one pixel per cycle
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_bank][wr_addr] <= wr_pixel;   // addr = (row/2)*(dim/2) + col/2
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// read side, one pixel from every bank per strobe
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rd.stb) begin
			for (int b = 0; b < `CNN_BANKS; b++) begin
				rd_data[b] <= mem[b][rd.addr[b]];   // held until the next strobe
			end
		end
	end

endmodule

// ==== verilog/conv_sequencer.sv ====
`include "cnn_cfg.svh"

module conv_sequencer (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   enable,
	output logic                   busy,
	output logic                   wr_en,
	output logic [1:0]             wr_bank,
	output cnn_pkg::bank_addr_t    wr_addr,
	output cnn_pkg::bank_rd_t      rd,
	output logic [1:0]             fetch_step,
	output logic                   fetch_valid,
	output logic                   cell_last,
	output logic [`CNN_RES_AW+1:0] pool_index,
	output logic                   done
);
	import cnn_pkg::*;

	localparam int DIM       = `CNN_IMG_DIM;
	localparam int HALF      = DIM / 2;
	localparam int POOL_DIM  = (DIM - 2) / 2;
	localparam int CW        = $clog2(DIM);
	localparam int DRAIN_CYC = 4;   // fetch data, window, sums, write

	typedef enum logic [1:0] {S_IDLE, S_LOAD, S_COMPUTE, S_DRAIN} state_t;

	state_t        state;
	logic [CW-1:0] row;      // load position
	logic [CW-1:0] col;
	logic [CW-1:0] cell_r;   // pooled cell being fetched
	logic [CW-1:0] cell_c;
	logic [1:0]    step;     // {block row, block col} inside the 4x4 window
	logic [2:0]    blk_sr;   // last block of a cell moving down the pipe
	logic [1:0]    drain_cnt;
	logic          load_last;
	bank_addr_t    blk_addr;

	////////////////////////////////////////////////////////////////////////////
	// load and fetch addressing
	////////////////////////////////////////////////////////////////////////////

	assign busy      = (state != S_LOAD);
	assign load_last = (row == CW'(DIM - 1)) && (col == CW'(DIM - 1));

	assign wr_en   = (state == S_LOAD);
	assign wr_bank = {row[0], col[0]};
	assign wr_addr = bank_addr_t'((row >> 1) * HALF + (col >> 1));

	// aligned 2x2 blocks land on the same address in every bank
	assign blk_addr = bank_addr_t'((cell_r + step[1]) * HALF + cell_c + step[0]);

	always_comb begin
		rd.addr = {`CNN_BANKS{blk_addr}};
		rd.stb  = (state == S_COMPUTE);
	end

	assign cell_last = (state == S_COMPUTE) && (step == 2'd3)
		&& (cell_r == CW'(POOL_DIM - 1)) && (cell_c == CW'(POOL_DIM - 1));

	////////////////////////////////////////////////////////////////////////////
	// run FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state       <= S_IDLE;
			row         <= '0;
			col         <= '0;
			cell_r      <= '0;
			cell_c      <= '0;
			step        <= '0;
			blk_sr      <= '0;
			drain_cnt   <= '0;
			fetch_valid <= 1'b0;
			fetch_step  <= '0;
			pool_index  <= '0;
			done        <= 1'b0;
		end else begin
			done        <= 1'b0;
			fetch_valid <= (state == S_COMPUTE);   // bank data is one cycle behind
			fetch_step  <= step;
			blk_sr      <= {blk_sr[1:0], (state == S_COMPUTE) && (step == 2'd3)};
			if (blk_sr[2]) begin
				pool_index <= pool_index + 1'b1;   // lines up with quad_valid
			end

			case (state)
				S_IDLE: begin
					row        <= '0;
					col        <= '0;
					cell_r     <= '0;
					cell_c     <= '0;
					step       <= '0;
					drain_cnt  <= '0;
					pool_index <= '0;
					if (enable) begin
						state <= S_LOAD;
					end
				end
				S_LOAD: begin
					if (col == CW'(DIM - 1)) begin
						col <= '0;
						row <= row + 1'b1;
					end else begin
						col <= col + 1'b1;
					end
					if (load_last) begin
						state <= S_COMPUTE;
					end
				end
				S_COMPUTE: begin
					step <= step + 1'b1;
					if (step == 2'd3) begin
						if (cell_c == CW'(POOL_DIM - 1)) begin
							cell_c <= '0;
							cell_r <= cell_r + 1'b1;
						end else begin
							cell_c <= cell_c + 1'b1;
						end
					end
					if (cell_last) begin
						state <= S_DRAIN;
					end
				end
				default: begin   // drain until the last write has gone out
					drain_cnt <= drain_cnt + 1'b1;
					if (drain_cnt == 2'(DRAIN_CYC - 1)) begin
						state <= S_IDLE;
						done  <= 1'b1;
					end
				end
			endcase
		end
	end

endmodule

// ==== verilog/window_conv.sv ====
`include "cnn_cfg.svh"

module window_conv (
	input  logic                clk,
	input  logic                rst_n,
	input  cnn_pkg::bank_data_t rd_data,
	input  logic [1:0]          fetch_step,
	input  logic                fetch_valid,
	input  cnn_pkg::kernel_t    kernel,
	output cnn_pkg::conv_quad_t quad,
	output logic                quad_valid
);
	import cnn_pkg::*;

	window_t win;
	logic    win_full;   // all four blocks in place

	// 3x3 dot product at window offset (r0, c0) plus the scaled bias
	function automatic acc_t dot3(window_t w, kernel_t k, int r0, int c0);
		acc_t sum;
		sum = acc_t'(k.bias) <<< `CNN_BIAS_ALIGN;
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++) begin
				sum += acc_t'(w[(r0 + i) * 4 + c0 + j]) * acc_t'(k.w[i * 3 + j]);
			end
		end
		return sum;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// window assembly
	////////////////////////////////////////////////////////////////////////////

	// step picks the quadrant, bank parity picks the pixel inside it
	always_ff @(posedge clk) begin
		if (fetch_valid) begin
			for (int b = 0; b < `CNN_BANKS; b++) begin
				win[(2 * fetch_step[1] + b / 2) * 4 + 2 * fetch_step[0] + b % 2] <= rd_data[b];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			win_full   <= 1'b0;
			quad_valid <= 1'b0;
		end else begin
			win_full   <= fetch_valid && (fetch_step == 2'd3);
			quad_valid <= win_full;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// four conv outputs under one pooling cell
	////////////////////////////////////////////////////////////////////////////

	// next cell's first block lands in the same edge, so win is still whole here
	always_ff @(posedge clk) begin
		if (win_full) begin
			for (int q = 0; q < 4; q++) begin
				quad[q] <= dot3(win, kernel, q / 2, q % 2);   // q = {row, col}
			end
		end
	end

endmodule

// ==== verilog/quant_pool_writer.sv ====
`include "cnn_cfg.svh"

module quant_pool_writer (
	input  logic                   clk,
	input  logic                   rst_n,
	input  cnn_pkg::conv_quad_t    quad,
	input  logic                   quad_valid,
	input  logic [2:0]             shift,
	input  logic [`CNN_RES_AW+1:0] pool_index,
	output cnn_pkg::res_wr_t       res_wr
);
	import cnn_pkg::*;

	localparam int PIX_MAX = 2 ** (`CNN_PIX_W - 1) - 1;
	localparam int PIX_MIN = -(2 ** (`CNN_PIX_W - 1));

	pixel_t                 q [4];
	pixel_t                 max_top;
	pixel_t                 max_bot;
	pixel_t                 pooled;
	logic [1:0]             lane;
	logic                   wen_q;
	logic [3:0]             mask_q;
	logic [`CNN_RES_AW-1:0] addr_q;
	logic [31:0]            data_q;

	// arithmetic shift then clamp to int8
	function automatic pixel_t quantize(acc_t sum, logic [2:0] sh);
		acc_t t;
		t = sum >>> sh;
		if (t > acc_t'(PIX_MAX)) return pixel_t'(PIX_MAX);
		if (t < acc_t'(PIX_MIN)) return pixel_t'(PIX_MIN);
		return pixel_t'(t);
	endfunction

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			q[i] = quantize(quad[i], shift);
		end
	end

	// 2x2 max pool
	assign max_top = (q[0] >= q[1]) ? q[0] : q[1];
	assign max_bot = (q[2] >= q[3]) ? q[2] : q[3];
	assign pooled  = (max_top >= max_bot) ? max_top : max_bot;
	assign lane    = pool_index[1:0];   // lane 0 is the top byte

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wen_q  <= 1'b1;
			mask_q <= 4'hf;
		end else begin
			wen_q  <= !quad_valid;
			mask_q <= quad_valid ? ~(4'b1000 >> lane) : 4'hf;
		end
	end

	always_ff @(posedge clk) begin
		if (quad_valid) begin
			addr_q <= pool_index[`CNN_RES_AW+1:2];
			data_q <= {pooled, 24'h0} >> (8 * lane);   // other lanes zero
		end
	end

	assign res_wr = '{wen: wen_q, addr: addr_q, data: data_q, bytemask: mask_q};

endmodule

// ==== verilog/conv_pool_top.sv ====
`include "cnn_cfg.svh"

module conv_pool_top (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             enable,
	input  cnn_pkg::pixel_t  input_data,
	output logic             busy,
	input  cnn_pkg::wb_req_t wb_req,
	output cnn_pkg::wb_rsp_t wb_rsp,
	output cnn_pkg::res_wr_t res_wr,
	output logic             done
);
	import cnn_pkg::*;

	kernel_t                kernel;
	logic                   wr_en;
	logic [1:0]             wr_bank;
	bank_addr_t             wr_addr;
	bank_rd_t               rd;
	bank_data_t             rd_data;
	logic [1:0]             fetch_step;
	logic                   fetch_valid;
	logic [`CNN_RES_AW+1:0] pool_index;
	conv_quad_t             quad;
	logic                   quad_valid;

	////////////////////////////////////////////////////////////////////////////
	// control and storage
	////////////////////////////////////////////////////////////////////////////

	kernel_regs u_kernel_regs (
		.clk    (clk),
		.rst_n  (rst_n),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp),
		.kernel (kernel)
	);

	conv_sequencer u_sequencer (
		.clk         (clk),
		.rst_n       (rst_n),
		.enable      (enable),
		.busy        (busy),
		.wr_en       (wr_en),
		.wr_bank     (wr_bank),
		.wr_addr     (wr_addr),
		.rd          (rd),
		.fetch_step  (fetch_step),
		.fetch_valid (fetch_valid),
		.cell_last   (),               // steers the drain inside the sequencer
		.pool_index  (pool_index),
		.done        (done)
	);

	image_bank_buffer u_buffer (
		.clk      (clk),
		.wr_en    (wr_en),
		.wr_bank  (wr_bank),
		.wr_addr  (wr_addr),
		.wr_pixel (input_data),
		.rd       (rd),
		.rd_data  (rd_data)
	);

	////////////////////////////////////////////////////////////////////////////
	// datapath
	////////////////////////////////////////////////////////////////////////////

	window_conv u_window_conv (
		.clk         (clk),
		.rst_n       (rst_n),
		.rd_data     (rd_data),
		.fetch_step  (fetch_step),
		.fetch_valid (fetch_valid),
		.kernel      (kernel),
		.quad        (quad),
		.quad_valid  (quad_valid)
	);

	quant_pool_writer u_writer (
		.clk        (clk),
		.rst_n      (rst_n),
		.quad       (quad),
		.quad_valid (quad_valid),
		.shift      (kernel.shift),
		.pool_index (pool_index),
		.res_wr     (res_wr)
	);

endmodule

// ==== tb/tb_conv_pool.sv ====
`include "cnn_cfg.svh"

module tb_conv_pool;
	import cnn_pkg::*;

	localparam int DIM   = `CNN_IMG_DIM;
	localparam int NPIX  = DIM * DIM;
	localparam int PDIM  = (DIM - 2) / 2;   // pooled map side
	localparam int NCELL = PDIM * PDIM;
	localparam int TMO   = 1000;

	logic    clk;
	logic    rst_n;
	logic    enable;
	pixel_t  input_data;
	logic    busy;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	res_wr_t res_wr;
	logic    done;

	pixel_t      img [NPIX];      // image model in raster order
	logic [7:0]  kregs [11];      // last bytes written to the register map
	int          w [9];
	int          bias;
	int          sh;
	logic [31:0] res_mem [4];     // result memory model
	logic [31:0] rng;
	string       cur_test;
	int          errors = 0;
	int          test_errs = 0;
	int          cycle = 0;
	int          write_count = 0;
	int          done_count = 0;
	int          last_wr_cycle = 0;
	logic [3:0]  exp_mask;
	logic [31:0] lane_bits;

	conv_pool_top DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.enable     (enable),
		.input_data (input_data),
		.busy       (busy),
		.wb_req     (wb_req),
		.wb_rsp     (wb_rsp),
		.res_wr     (res_wr),
		.done       (done)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// random numbers and reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [7:0] next_random();
		rng = xorshift(rng);
		return rng[15:8];
	endfunction

	// low nibble as a signed 4-bit value
	function automatic int nibble_value(logic [7:0] d);
		return d[3] ? int'(d[3:0]) - 16 : int'(d[3:0]);
	endfunction

	// model of the pooled byte at cell (r, c)
	function automatic int model_cell(int r, int c);
		int best;
		int sum;
		best = -1000;
		for (int i = 0; i < 2; i++) begin
			for (int j = 0; j < 2; j++) begin
				sum = bias * (1 << `CNN_BIAS_ALIGN);
				for (int a = 0; a < 3; a++) begin
					for (int b = 0; b < 3; b++) begin
						sum += w[a * 3 + b] * int'(img[(2 * r + i + a) * DIM + 2 * c + j + b]);
					end
				end
				sum = sum >>> sh;
				if (sum > 127) sum = 127;
				if (sum < -128) sum = -128;
				if (sum > best) best = sum;
			end
		end
		return best;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// reporting
	////////////////////////////////////////////////////////////////////////////

	task automatic expect_eq(string what, int expected, int actual);
		assert (expected == actual) else begin
			$display("FAIL %s (%s): expected %0d, actual %0d", cur_test, what, expected, actual);
			errors++;
		end
	endtask

	task automatic abort_run(string why);
		$display("timeout in %s: %s", cur_test, why);
		$display("Some tests failed");
		$finish;
	endtask

	task automatic open_test(string name);
		cur_test  = name;
		test_errs = errors;
	endtask

	task automatic report_test(int num);
		$display("test %0d %s finished with %0d errors", num, cur_test, errors - test_errs);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// bus and stream drivers
	////////////////////////////////////////////////////////////////////////////

	task automatic wb_access(logic we, logic [3:0] adr, logic [7:0] wdat,
		output logic [7:0] rdat);
		int n;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = we;
		wb_req.adr = adr;
		wb_req.dat = wdat;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > 20) abort_run("no Wishbone ack");
		end while (!wb_rsp.ack);
		rdat       = wb_rsp.dat;
		wb_req.cyc = 1'b0;   // drop before the next edge
		wb_req.stb = 1'b0;
		wb_req.we  = 1'b0;
	endtask

	task automatic random_kernel(logic [2:0] shift_bits);
		logic [7:0] r;
		for (int a = 0; a < 10; a++) begin
			kregs[a] = next_random();
		end
		r = next_random();
		kregs[10] = {r[7:3], shift_bits};   // upper bits go nowhere
	endtask

	task automatic load_kernel();
		logic [7:0] rd_dummy;
		for (int a = 0; a < 11; a++) begin
			wb_access(1'b1, 4'(a), kregs[a], rd_dummy);
		end
		for (int a = 0; a < 9; a++) begin
			w[a] = nibble_value(kregs[a]);
		end
		bias = nibble_value(kregs[9]);
		sh   = int'(kregs[10][2:0]);
	endtask

	task automatic random_image();
		for (int i = 0; i < NPIX; i++) begin
			img[i] = pixel_t'(next_random());
		end
	endtask

	task automatic clear_results();
		for (int a = 0; a < 4; a++) begin
			res_mem[a] = {4{8'hc3 ^ 8'(a)}};
		end
		write_count = 0;
		done_count  = 0;
	endtask

	// raise enable and feed one pixel per cycle while busy is low
	task automatic stream_image(output int low_cycles);
		int n;
		enable = 1'b1;
		n = 0;
		@(negedge clk);
		while (busy) begin
			n++;
			if (n > 20) abort_run("busy never went low after enable");
			@(negedge clk);
		end
		expect_eq("cycles from enable to busy low", 0, n);
		enable     = 1'b0;
		low_cycles = 0;
		while (!busy) begin
			input_data = (low_cycles < NPIX) ? img[low_cycles] : '0;
			low_cycles++;
			if (low_cycles > 2 * NPIX) abort_run("busy stuck low");
			@(negedge clk);
		end
		input_data = '0;
	endtask

	task automatic wait_done();
		int n;
		int busy_drops;
		n = 0;
		busy_drops = 0;
		while (!done) begin
			if (!busy) busy_drops++;
			n++;
			if (n > TMO) abort_run("done never pulsed");
			@(negedge clk);
		end
		expect_eq("busy low after load", 0, busy_drops);
		repeat (4) @(negedge clk);   // room for a stray second done
	endtask

	task automatic compare_results();
		logic signed [7:0] got;
		for (int k = 0; k < NCELL; k++) begin
			got = res_mem[k / 4][8 * (3 - k % 4) +: 8];
			expect_eq($sformatf("cell %0d", k), model_cell(k / PDIM, k % PDIM), int'(got));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// result port monitor
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		cycle++;
		if (rst_n && !res_wr.wen) begin
			exp_mask  = 4'hf;
			exp_mask[3 - write_count % 4] = 1'b0;   // lane 0 is the top byte
			lane_bits = '0;
			lane_bits[8 * (3 - write_count % 4) +: 8] = 8'hff;
			expect_eq("write address", write_count / 4, int'(res_wr.addr));
			expect_eq("write bytemask", int'(exp_mask), int'(res_wr.bytemask));
			expect_eq("unmasked lanes", 0, int'(res_wr.data & ~lane_bits));
			for (int b = 0; b < 4; b++) begin
				if (!res_wr.bytemask[b]) res_mem[res_wr.addr][8 * b +: 8] = res_wr.data[8 * b +: 8];
			end
			write_count++;
			last_wr_cycle = cycle;
		end
		if (rst_n && done) begin
			done_count++;
			expect_eq("done cycle after last write", last_wr_cycle + 1, cycle);
			expect_eq("writes before done", NCELL, write_count);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [7:0]        rdat;
		logic signed [7:0] got;
		int                low_cycles;
		int                n_max;
		int                n_min;
		rng        = 32'h6c96;
		rst_n      = 1'b0;
		enable     = 1'b0;
		input_data = '0;
		wb_req     = '0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		open_test("reset_and_registers");
		expect_eq("busy after reset", 1, int'(busy));
		expect_eq("done after reset", 0, int'(done));
		expect_eq("wen after reset", 1, int'(res_wr.wen));
		expect_eq("bytemask after reset", 15, int'(res_wr.bytemask));
		expect_eq("ack after reset", 0, int'(wb_rsp.ack));
		random_kernel(3'd5);
		load_kernel();
		for (int a = 0; a < 11; a++) begin
			wb_access(1'b0, 4'(a), 8'h00, rdat);
			expect_eq($sformatf("read reg %0d", a),
				int'(kregs[a] & ((a == 10) ? 8'h07 : 8'h0f)), int'(rdat));
		end
		wb_access(1'b1, 4'd12, 8'hff, rdat);
		wb_access(1'b0, 4'd12, 8'h00, rdat);
		expect_eq("read unmapped reg", 0, int'(rdat));
		report_test(1);

		open_test("stream_busy_window");
		random_image();
		clear_results();
		stream_image(low_cycles);
		expect_eq("busy low cycles", NPIX, low_cycles);
		report_test(2);

		open_test("random_kernel_results");
		wait_done();
		compare_results();
		report_test(3);

		open_test("write_format_and_done");
		expect_eq("result writes", NCELL, write_count);
		expect_eq("done pulses", 1, done_count);
		report_test(4);

		// top half at +127 and bottom half at -128 with all weights at +7
		open_test("saturation");
		for (int a = 0; a < 10; a++) begin
			kregs[a] = 8'h07;
		end
		kregs[10] = 8'h00;
		load_kernel();
		for (int i = 0; i < NPIX; i++) begin
			img[i] = (i < NPIX / 2) ? pixel_t'(127) : pixel_t'(-128);
		end
		clear_results();
		stream_image(low_cycles);
		wait_done();
		compare_results();
		n_max = 0;
		n_min = 0;
		for (int k = 0; k < NCELL; k++) begin
			got = res_mem[k / 4][8 * (3 - k % 4) +: 8];
			if (got == 8'sd127) n_max++;
			if (got == -8'sd128) n_min++;
		end
		assert (n_max > 0 && n_min > 0) else begin
			$display("saturation run did not clip cells to both 127 and -128");
			errors++;
		end
		expect_eq("done pulses", 1, done_count);
		report_test(5);

		open_test("second_run_new_kernel");
		random_kernel(3'd3);
		load_kernel();
		random_image();
		clear_results();
		stream_image(low_cycles);
		expect_eq("busy low cycles", NPIX, low_cycles);
		wait_done();
		compare_results();
		expect_eq("result writes", NCELL, write_count);
		expect_eq("done pulses", 1, done_count);
		report_test(6);

		$display("6 tests run, %0d checks failed", errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/cnn_pkg.sv
verilog/kernel_regs.sv
verilog/image_bank_buffer.sv
verilog/conv_sequencer.sv
verilog/window_conv.sv
verilog/quant_pool_writer.sv
verilog/conv_pool_top.sv
tb/tb_conv_pool.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module tb_conv_pool -Mdir obj_dir -o sim_conv_pool
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/sim_conv_pool)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "All tests passed"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
